//--- build.f
logic/fetch_pkg.sv
logic/icache_pkg.sv
logic/fetch_fsm.sv
logic/fetch_pc.sv
logic/icache.sv
logic/fetch_buffers.sv
logic/fetch_unit.sv
verification/fetch_unit_sva.sv
verification/tb_fetch_unit.sv

//--- build.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_fetch_unit \
  -Mdir obj_dir -o sim_fetch_unit
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_fetch_unit > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1

//--- verification/tb_fetch_unit.sv
module tb_fetch_unit;

  localparam int          clk_period   = 100;
  localparam logic [31:0] reset_vector = 32'h0000_1000;
  localparam int          load_timeout = 20;
  localparam int          load_waits   = 9;
  // Fixed-length steps of all tests, in cycles.
  localparam int          fixed_cycles = 70;
  localparam int          watchdog_cycles = 3 + fixed_cycles + load_waits * load_timeout + 50;

  logic                    clk;
  logic                    rst_n;
  logic                    intr;
  logic                    ic_exp;
  logic                    dc_exp;
  logic                    de_br_stall;
  logic [31:0]             redirect_addr;
  logic                    de_p;
  logic                    r_V_de;
  logic                    fill_valid;
  logic [31:0]             fill_addr;
  icache_pkg::line_t       fill_data;
  icache_pkg::line_t       buf0;
  icache_pkg::line_t       buf1;
  logic [1:0]              buf_valid;
  logic [31:0]             fetch_addr;
  fetch_pkg::fetch_state_t fetch_state;
  logic                    ic_miss;

  integer                  seed = 32'h48c92a5e;
  string                   test_name;
  // Memory behind the cache, one entry per line address.
  icache_pkg::line_t       line_model [logic [31:0]];

  fetch_unit #(.icache_lines(16), .reset_vector(reset_vector)) DUT (
    .clk(clk), .rst_n(rst_n), .intr(intr), .ic_exp(ic_exp), .dc_exp(dc_exp),
    .de_br_stall(de_br_stall), .redirect_addr(redirect_addr), .de_p(de_p),
    .r_V_de(r_V_de), .fill_valid(fill_valid), .fill_addr(fill_addr),
    .fill_data(fill_data), .buf0(buf0), .buf1(buf1), .buf_valid(buf_valid),
    .fetch_addr(fetch_addr), .fetch_state(fetch_state), .ic_miss(ic_miss)
  );

  always #(clk_period / 2) clk = ~clk;

  task abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task check_value(input string what, input logic [127:0] actual,
                   input logic [127:0] expected);
    if (expected !== actual) begin
      $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      abort_run("check failed");
    end
  endtask

  function icache_pkg::line_t model_line(input logic [31:0] addr);
    logic [31:0] key;
    key = addr & ~32'hf;
    if (!line_model.exists(key)) begin
      line_model[key] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    return line_model[key];
  endfunction

  task fill_line(input logic [31:0] addr);
    fill_valid = 1'b1;
    fill_addr  = addr;
    fill_data  = model_line(addr);
    @(negedge clk);
    fill_valid = 1'b0;
  endtask

  task wait_for_load(input int idx);
    int n;
    n = 0;
    while (buf_valid[idx] !== 1'b1 && n < load_timeout) begin
      @(negedge clk);
      n = n + 1;
    end
    if (buf_valid[idx] !== 1'b1) begin
      abort_run($sformatf("%s: buffer %0d was never loaded", test_name, idx));
    end
  endtask

  // Source 0 is intr, then ic_exp, dc_exp and de_br_stall.
  task pulse_flush(input int src, input logic [31:0] addr);
    {intr, ic_exp, dc_exp, de_br_stall} = 4'b1000 >> src;
    redirect_addr = addr;
    @(negedge clk);
    {intr, ic_exp, dc_exp, de_br_stall} = 4'b0000;
    check_value("state after flush", 128'(fetch_state), 128'(fetch_pkg::idle));
    check_value("valid after flush", 128'(buf_valid), 128'(2'b00));
    check_value("redirected address", 128'(fetch_addr), 128'(addr & ~32'hf));
  endtask

  task after_reset;
    test_name = "reset";
    check_value("buf_valid", 128'(buf_valid), 128'(2'b00));
    check_value("state", 128'(fetch_state), 128'(fetch_pkg::idle));
    check_value("fetch_addr", 128'(fetch_addr), 128'(reset_vector));
  endtask

  task miss_then_fill;
    test_name = "miss then fill";
    repeat (4) begin
      @(negedge clk);
      check_value("ic_miss", 128'(ic_miss), 128'(1'b1));
      check_value("state", 128'(fetch_state), 128'(fetch_pkg::idle));
    end
    fill_line(reset_vector);
    wait_for_load(0);
    check_value("buf0", buf0, model_line(reset_vector));
    check_value("state", 128'(fetch_state), 128'(fetch_pkg::state_01));
    check_value("fetch_addr", 128'(fetch_addr), 128'(reset_vector + 32'h10));
    fill_line(reset_vector + 32'h10);
    wait_for_load(1);
    check_value("buf1", buf1, model_line(reset_vector + 32'h10));
    check_value("state", 128'(fetch_state), 128'(fetch_pkg::state_11));
    check_value("fetch_addr", 128'(fetch_addr), 128'(reset_vector + 32'h20));
    // Both buffers are full, so the uncached next line is not requested.
    check_value("ic_miss when full", 128'(ic_miss), 128'(1'b0));
  endtask

  task odd_line_start;
    test_name = "odd start";
    fill_line(32'h2010);
    pulse_flush(0, 32'h2014);
    wait_for_load(1);
    check_value("state", 128'(fetch_state), 128'(fetch_pkg::state_10));
    check_value("buf_valid", 128'(buf_valid), 128'(2'b10));
    check_value("buf1", buf1, model_line(32'h2010));
    fill_line(32'h2020);
    wait_for_load(0);
    check_value("buf0", buf0, model_line(32'h2020));
    check_value("state", 128'(fetch_state), 128'(fetch_pkg::state_11));
    check_value("fetch_addr", 128'(fetch_addr), 128'(32'h2030));
  endtask

  task buffer_consumption;
    logic [31:0] addr;
    test_name = "consumption";
    for (int k = 0; k < 3; k++) begin
      fill_line(32'h2030 + 32'(16 * k));
    end
    // The decoder alternates, starting in buffer 1 which holds the odd line.
    for (int k = 0; k < 3; k++) begin
      addr   = 32'h2030 + 32'(16 * k);
      r_V_de = 1'b1;
      de_p   = (k % 2 == 0);
      @(negedge clk);
      r_V_de = 1'b0;
      check_value("reloaded buffer", de_p ? buf1 : buf0, model_line(addr));
      check_value("fetch_addr", 128'(fetch_addr), 128'(addr + 32'h10));
      check_value("buf_valid", 128'(buf_valid), 128'(2'b11));
    end
    // Next line is not cached yet.
    r_V_de = 1'b1;
    de_p   = 1'b0;
    @(negedge clk);
    r_V_de = 1'b0;
    check_value("stall state", 128'(fetch_state), 128'(fetch_pkg::fe_stall_11));
    check_value("ic_miss", 128'(ic_miss), 128'(1'b1));
    fill_line(32'h2060);
    wait_for_load(0);
    check_value("buf0", buf0, model_line(32'h2060));
    check_value("state", 128'(fetch_state), 128'(fetch_pkg::state_11));
    check_value("fetch_addr", 128'(fetch_addr), 128'(32'h2070));
  endtask

  task back_pressure_hold;
    icache_pkg::line_t held0;
    icache_pkg::line_t held1;
    logic [31:0]       held_addr;
    test_name = "back-pressure";
    fill_line(32'h2070);
    held0     = buf0;
    held1     = buf1;
    held_addr = fetch_addr;
    repeat (20) begin
      @(negedge clk);
      check_value("buf0", buf0, held0);
      check_value("buf1", buf1, held1);
      check_value("buf_valid", 128'(buf_valid), 128'(2'b11));
      check_value("fetch_addr", 128'(fetch_addr), 128'(held_addr));
      check_value("state", 128'(fetch_state), 128'(fetch_pkg::state_11));
    end
  endtask

  task flush_each_source;
    logic [31:0] targets [4];
    test_name = "flush";
    targets = '{32'h2047, 32'h2035, 32'h2068, 32'h2023};
    // Targets are cached lines, so a buffer is full again before the next flush.
    for (int src = 0; src < 4; src++) begin
      pulse_flush(src, targets[src]);
      wait_for_load(targets[src][4]);
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    {intr, ic_exp, dc_exp, de_br_stall} = 4'b0000;
    redirect_addr = '0;
    de_p          = 1'b0;
    r_V_de        = 1'b0;
    fill_valid    = 1'b0;
    fill_addr     = '0;
    fill_data     = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    after_reset();
    miss_then_fill();
    odd_line_start();
    buffer_consumption();
    back_pressure_hold();
    flush_each_source();
    @(negedge clk);
    if (DUT.u_sva.failures != 0) begin
      $display("%0d assertion failures during the run", DUT.u_sva.failures);
      $display("tests failed");
      $fatal(1);
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog: run exceeded %0d cycles", watchdog_cycles);
    $display("tests failed");
    $fatal(1);
  end

endmodule

//--- verification/fetch_unit_sva.sv
module fetch_unit_sva (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    flush,
  input logic                    de_p,
  input logic                    r_V_de,
  input logic [1:0]              buf_valid,
  input fetch_pkg::ld_buf_t      f_ld_buf,
  input fetch_pkg::fetch_state_t fetch_state
);

  int failures = 0;

  state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_state inside {fetch_pkg::idle, fetch_pkg::state_10, fetch_pkg::state_01,
                        fetch_pkg::state_11, fetch_pkg::fe_stall_11, fetch_pkg::fe_stall_01})
  else begin
    $error("fetch state %b is not a legal encoding", fetch_state);
    failures = failures + 1;
  end

  // A full buffer 0 may only be refilled in the cycle it is consumed.
  buf0_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    (buf_valid[0] && !(r_V_de && !de_p)) |-> !f_ld_buf[0])
  else begin
    $error("buffer 0 loaded while it still held an unconsumed line");
    failures = failures + 1;
  end

  flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> (fetch_state == fetch_pkg::idle) && (buf_valid == 2'b00))
  else begin
    $error("flush did not return to idle with both buffers empty");
    failures = failures + 1;
  end

endmodule

bind fetch_unit fetch_unit_sva u_sva (
  .clk(clk), .rst_n(rst_n), .flush(flush), .de_p(de_p), .r_V_de(r_V_de),
  .buf_valid(buf_valid), .f_ld_buf(f_ld_buf), .fetch_state(fetch_state)
);

//--- logic/fetch_unit.sv
module fetch_unit #(
  parameter int          icache_lines = 16,
  parameter logic [31:0] reset_vector = 32'h0000_1000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    intr,
  input  logic                    ic_exp,
  input  logic                    dc_exp,
  input  logic                    de_br_stall,
  input  logic [31:0]             redirect_addr,
  input  logic                    de_p,
  input  logic                    r_V_de,
  input  logic                    fill_valid,
  input  logic [31:0]             fill_addr,
  input  icache_pkg::line_t       fill_data,
  output icache_pkg::line_t       buf0,
  output icache_pkg::line_t       buf1,
  output logic [1:0]              buf_valid,
  output logic [31:0]             fetch_addr,
  output fetch_pkg::fetch_state_t fetch_state,
  output logic                    ic_miss
);

  logic                    flush;
  logic                    eip_4;
  logic                    ic_hit;
  logic                    f_address_sel;
  fetch_pkg::ld_buf_t      f_ld_buf;
  icache_pkg::line_t       hit_data;
  icache_pkg::fetch_addr_u lookup_addr;

  assign flush = intr | ic_exp | dc_exp | de_br_stall;
  assign lookup_addr.flat = fetch_addr;

  // Only the full state is not looking for a line.
  assign ic_miss = !ic_hit && (fetch_state != fetch_pkg::state_11);

  icache #(.icache_lines(icache_lines)) u_icache (
    .clk(clk), .rst_n(rst_n), .lookup_addr(lookup_addr),
    .fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data),
    .ic_hit(ic_hit), .hit_data(hit_data)
  );

  fetch_pc #(.reset_vector(reset_vector)) u_fetch_pc (
    .clk(clk), .rst_n(rst_n), .flush(flush), .redirect_addr(redirect_addr),
    .address_sel(f_address_sel), .ld_buf(f_ld_buf),
    .fetch_addr(fetch_addr), .eip_4(eip_4)
  );

  fetch_fsm u_fetch_fsm (
    .clk(clk), .rst_n(rst_n), .flush(flush), .eip_4(eip_4), .ic_hit(ic_hit),
    .de_p(de_p), .r_V_de(r_V_de), .f_ld_buf(f_ld_buf),
    .f_address_sel(f_address_sel), .f_curr_st(fetch_state)
  );

  fetch_buffers u_fetch_buffers (
    .clk(clk), .rst_n(rst_n), .flush(flush), .ld_buf(f_ld_buf),
    .line_in(hit_data), .de_p(de_p), .r_V_de(r_V_de),
    .buf0(buf0), .buf1(buf1), .buf_valid(buf_valid)
  );

endmodule

//--- logic/fetch_buffers.sv
module fetch_buffers (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,
  input  fetch_pkg::ld_buf_t ld_buf,
  input  icache_pkg::line_t  line_in,
  input  logic               de_p,
  input  logic               r_V_de,
  output icache_pkg::line_t  buf0,
  output icache_pkg::line_t  buf1,
  output logic [1:0]         buf_valid
);

  icache_pkg::line_t buf_q [2];
  logic [1:0]        consumed;

  assign consumed = r_V_de ? (de_p ? 2'b10 : 2'b01) : 2'b00;

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (ld_buf[i]) begin
        buf_q[i] <= line_in;
      end
    end
  end

  // A load wins over a consume of the same buffer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_valid <= 2'b00;
    end else if (flush) begin
      buf_valid <= 2'b00;
    end else begin
      buf_valid <= (buf_valid & ~consumed) | ld_buf;
    end
  end

  assign buf0 = buf_q[0];
  assign buf1 = buf_q[1];

endmodule

//--- logic/icache.sv
module icache #(
  parameter int icache_lines = 16
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  icache_pkg::fetch_addr_u lookup_addr,
  input  logic                    fill_valid,
  input  logic [31:0]             fill_addr,
  input  icache_pkg::line_t       fill_data,
  output logic                    ic_hit,
  output icache_pkg::line_t       hit_data
);

  localparam int idx_bits = $clog2(icache_lines);
  // Upper index bits not used for addressing are kept with the tag.
  localparam int stored_bits = 32 - icache_pkg::offset_bits - idx_bits;

  icache_pkg::fetch_addr_u fill_u;
  logic [idx_bits-1:0]     rd_idx;
  logic [idx_bits-1:0]     wr_idx;
  logic [stored_bits-1:0]  rd_tag;
  logic [stored_bits-1:0]  wr_tag;

  logic [stored_bits-1:0]  tag_mem  [icache_lines];
  icache_pkg::line_t       data_mem [icache_lines];
  logic [icache_lines-1:0] valid_q;

  assign fill_u.flat = fill_addr;
  assign rd_idx = lookup_addr.fields.index[idx_bits-1:0];
  assign wr_idx = fill_u.fields.index[idx_bits-1:0];
  assign rd_tag = {lookup_addr.fields.tag,
                   lookup_addr.fields.index[icache_pkg::max_index_bits-1:idx_bits]};
  assign wr_tag = {fill_u.fields.tag,
                   fill_u.fields.index[icache_pkg::max_index_bits-1:idx_bits]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (fill_valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_valid) begin
      tag_mem[wr_idx]  <= wr_tag;
      data_mem[wr_idx] <= fill_data;
    end
  end

  assign ic_hit   = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign hit_data = data_mem[rd_idx];

endmodule

//--- logic/fetch_pc.sv
module fetch_pc #(
  parameter logic [31:0] reset_vector = 32'h0000_1000
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,
  input  logic [31:0]        redirect_addr,
  input  logic               address_sel,
  input  fetch_pkg::ld_buf_t ld_buf,
  output logic [31:0]        fetch_addr,
  output logic               eip_4
);

  icache_pkg::fetch_addr_u pc_q;
  logic                    advance;

  assign advance = address_sel && (ld_buf != fetch_pkg::ld_none);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q.flat <= reset_vector;
    end else if (flush) begin
      // Fetch works on whole lines.
      pc_q.flat <= redirect_addr & ~32'(icache_pkg::line_bytes - 1);
    end else if (advance) begin
      pc_q.flat <= pc_q.flat + 32'(icache_pkg::line_bytes);
    end
  end

  assign fetch_addr = pc_q.flat;
  assign eip_4      = pc_q.flat[4];

endmodule

//--- logic/fetch_fsm.sv
module fetch_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic                   eip_4,
  input  logic                   ic_hit,
  input  logic                   de_p,
  input  logic                   r_V_de,
  output fetch_pkg::ld_buf_t     f_ld_buf,
  output logic                   f_address_sel,
  output fetch_pkg::fetch_state_t f_curr_st
);

  fetch_pkg::fetch_state_t f_next_st;
  logic                    next_f_address_sel;
  logic                    consume_b0;
  logic                    consume_b1;

  assign consume_b0 = r_V_de && !de_p;
  assign consume_b1 = r_V_de && de_p;

  always_comb begin
    f_next_st          = f_curr_st;
    f_ld_buf           = fetch_pkg::ld_none;
    next_f_address_sel = 1'b1;
    case (f_curr_st)
      fetch_pkg::idle: begin
        // First idle cycle after reset or flush is a lookup only.
        if (ic_hit && f_address_sel) begin
          if (eip_4) begin
            f_next_st = fetch_pkg::state_10;
            f_ld_buf  = fetch_pkg::ld_b1;
          end else begin
            f_next_st = fetch_pkg::state_01;
            f_ld_buf  = fetch_pkg::ld_b0;
          end
        end
      end
      fetch_pkg::state_10: begin
        // Buffer 1 full, fetching the even line for buffer 0.
        if (ic_hit) begin
          f_ld_buf  = fetch_pkg::ld_b0;
          f_next_st = consume_b1 ? fetch_pkg::state_01 : fetch_pkg::state_11;
        end else if (consume_b1) begin
          f_next_st = fetch_pkg::idle;
        end
      end
      fetch_pkg::state_01: begin
        if (ic_hit) begin
          f_ld_buf  = fetch_pkg::ld_b1;
          f_next_st = consume_b0 ? fetch_pkg::state_10 : fetch_pkg::state_11;
        end else if (consume_b0) begin
          f_next_st = fetch_pkg::idle;
        end
      end
      fetch_pkg::state_11: begin
        // Refill only the buffer whose parity matches the next line.
        if (consume_b0 && !eip_4) begin
          if (ic_hit) begin
            f_ld_buf = fetch_pkg::ld_b0;
          end else begin
            f_next_st = fetch_pkg::fe_stall_11;
          end
        end else if (consume_b1 && eip_4) begin
          if (ic_hit) begin
            f_ld_buf = fetch_pkg::ld_b1;
          end else begin
            f_next_st = fetch_pkg::fe_stall_01;
          end
        end
      end
      fetch_pkg::fe_stall_11: begin
        if (ic_hit) begin
          f_ld_buf  = fetch_pkg::ld_b0;
          f_next_st = fetch_pkg::state_11;
        end
      end
      fetch_pkg::fe_stall_01: begin
        if (ic_hit) begin
          f_ld_buf  = fetch_pkg::ld_b1;
          f_next_st = fetch_pkg::state_11;
        end
      end
      default: begin
        f_next_st          = fetch_pkg::idle;
        next_f_address_sel = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      f_curr_st     <= fetch_pkg::idle;
      f_address_sel <= 1'b0;
    end else if (flush) begin
      f_curr_st     <= fetch_pkg::idle;
      f_address_sel <= 1'b0;
    end else begin
      f_curr_st     <= f_next_st;
      f_address_sel <= next_f_address_sel;
    end
  end

endmodule

//--- logic/icache_pkg.sv
package icache_pkg;

  localparam int line_bytes     = 16;
  localparam int line_bits      = 128;
  localparam int offset_bits    = 4;
  localparam int max_index_bits = 8;
  localparam int tag_bits       = 32 - max_index_bits - offset_bits;

  typedef logic [line_bits-1:0] line_t;

  typedef struct packed {
    logic [tag_bits-1:0]       tag;
    logic [max_index_bits-1:0] index;
    logic [offset_bits-1:0]    offset;
  } addr_fields_t;

  // The low index bit (address bit 4) is the line parity.
  typedef union packed {
    logic [31:0]  flat;
    addr_fields_t fields;
  } fetch_addr_u;

endpackage

//--- logic/fetch_pkg.sv
package fetch_pkg;

  // Each state name gives the buffers holding a line, as {buffer 1, buffer 0}.
  // The stall states wait on a cache refill after a consume.
  typedef enum logic [2:0] {
    idle        = 3'b000,
    state_10    = 3'b110,
    state_01    = 3'b101,
    state_11    = 3'b111,
    fe_stall_11 = 3'b011,
    fe_stall_01 = 3'b001
  } fetch_state_t;

  // Bit 1 loads buffer 1, bit 0 loads buffer 0.
  typedef logic [1:0] ld_buf_t;

  localparam ld_buf_t ld_none = 2'b00;
  localparam ld_buf_t ld_b0   = 2'b01;
  localparam ld_buf_t ld_b1   = 2'b10;
  localparam ld_buf_t ld_both = 2'b11;

endpackage
